// File: cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    localparam int data_w = 32;
    localparam int reg_aw = 3;
    localparam int n_regs = 1 << reg_aw;
    localparam int op_w = 6;
    localparam int imm_w = 16;
    localparam logic [data_w-1:0] reset_pc = '0;

    // Fetch sequencer
    localparam logic [1:0] fs_idle = 2'd0;         // only seen out of reset
    localparam logic [1:0] fs_fetch = 2'd1;        // instruction request on the bus
    localparam logic [1:0] fs_wait_data = 2'd2;
    localparam logic [1:0] fs_wait_retire = 2'd3;

    typedef enum logic [op_w-1:0] {
        op_add  = 6'h00,
        op_sub  = 6'h01,
        op_and  = 6'h02,
        op_or   = 6'h03,
        op_xor  = 6'h04,
        op_shl  = 6'h05,
        op_shr  = 6'h06,
        op_addi = 6'h08,
        op_ldi  = 6'h09,
        op_ld   = 6'h0a,
        op_st   = 6'h0b,
        op_bz   = 6'h0c,
        op_bnz  = 6'h0d,
        op_jmp  = 6'h0e,
        op_halt = 6'h0f
    } opcode_t;

    // rd = ra op rb
    typedef struct packed {
        opcode_t opcode;
        logic [reg_aw-1:0] rd;
        logic [reg_aw-1:0] ra;
        logic [reg_aw-1:0] rb;
        logic [16:0] spare;
    } instr_r_t;

    // imm is sign-extended by decode
    typedef struct packed {
        opcode_t opcode;
        logic [reg_aw-1:0] rd;
        logic [reg_aw-1:0] ra;
        logic [3:0] spare;
        logic [imm_w-1:0] imm;
    } instr_i_t;

    typedef union packed {
        instr_r_t r;
        instr_i_t i;
    } instr_u;

endpackage

`default_nettype wire

// File: cpu_if.sv
`timescale 1ns/1ps
`default_nettype none

interface issue_if;
    import cpu_pkg::*;

    logic valid;
    opcode_t opcode;
    logic [reg_aw-1:0] rd;
    logic [data_w-1:0] op_a;
    logic [data_w-1:0] op_b;
    logic [data_w-1:0] imm;
    logic flag_a;
    logic [data_w-1:0] pc;

    modport issue (output valid, opcode, rd, op_a, op_b, imm, flag_a, pc);
    modport accept (input valid, opcode, rd, op_a, op_b, imm, flag_a, pc);
endinterface

interface bus_req_if;
    import cpu_pkg::*;

    logic req;
    logic rw;
    logic [data_w-1:0] addr;
    logic [data_w-1:0] wdata;
    logic redirect;
    logic [data_w-1:0] target;
    logic done;
    logic ld_valid;
    logic [data_w-1:0] ld_data;

    modport master (output req, rw, addr, wdata, redirect, target, done,
                    input ld_valid, ld_data);
    modport slave (input req, rw, addr, wdata, redirect, target, done,
                   output ld_valid, ld_data);
endinterface

`default_nettype wire

// File: cpu_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_fetch (
    input  logic clock,
    input  logic arst_n,
    input  logic [cpu_pkg::data_w-1:0] data,
    output logic [cpu_pkg::data_w-1:0] address,
    output logic [cpu_pkg::data_w-1:0] datao,
    output logic rw,
    output logic mem_req,
    output logic instr_valid,
    output cpu_pkg::instr_u instr,
    output logic [cpu_pkg::data_w-1:0] pc,
    bus_req_if.slave bus
);
    import cpu_pkg::*;

    logic [1:0] state;
    logic ld_pend;    // load data on the bus this cycle

    // Fetch requests come from the state, data requests pass straight through
    assign mem_req = (state == fs_fetch) | bus.req;
    assign rw = bus.req & bus.rw;
    assign address = bus.req ? bus.addr : pc;
    assign datao = bus.wdata;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state <= fs_idle;
            pc <= reset_pc;
            instr_valid <= 1'b0;
            ld_pend <= 1'b0;
            bus.ld_valid <= 1'b0;
        end else begin
            instr_valid <= (state == fs_wait_data);
            ld_pend <= bus.req & ~bus.rw;
            bus.ld_valid <= ld_pend;
            case (state)
                fs_idle: state <= fs_fetch;
                fs_fetch: state <= fs_wait_data;
                fs_wait_data: state <= fs_wait_retire;
                default: begin
                    if (bus.done) begin
                        state <= fs_fetch;
                        pc <= bus.redirect ? bus.target : pc + 1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == fs_wait_data) begin
            instr <= data;
        end
        if (ld_pend) begin
            bus.ld_data <= data;
        end
    end

    // Execute only talks to the bus once the instruction word is in
    a_req_after_fetch: assert property (@(posedge clock) disable iff (!arst_n)
        bus.req |-> state == fs_wait_retire)
        else $error("data request while an instruction fetch is outstanding");

endmodule

`default_nettype wire

// File: cpu_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_regfile (
    input  logic clock,
    input  logic arst_n,
    input  logic [cpu_pkg::reg_aw-1:0] ra_addr,
    input  logic [cpu_pkg::reg_aw-1:0] rb_addr,
    output logic [cpu_pkg::data_w-1:0] ra_data,
    output logic [cpu_pkg::data_w-1:0] rb_data,
    output logic ra_flag,
    input  logic we,
    input  logic [cpu_pkg::reg_aw-1:0] waddr,
    input  logic [cpu_pkg::data_w-1:0] wdata
);
    import cpu_pkg::*;

    logic [data_w-1:0] regs [n_regs];
    logic [n_regs-1:0] zflag;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int k = 0; k < n_regs; k++) begin
                regs[k] <= '0;
            end
            zflag <= '1;    // all registers start at zero
        end else if (we) begin
            regs[waddr] <= wdata;
            zflag[waddr] <= (wdata == '0);
        end
    end

    // No write-through, one instruction in flight
    assign ra_data = regs[ra_addr];
    assign rb_data = regs[rb_addr];
    assign ra_flag = zflag[ra_addr];

endmodule

`default_nettype wire

// File: cpu_decode.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_decode (
    input  logic clock,
    input  logic arst_n,
    input  logic instr_valid,
    input  cpu_pkg::instr_u instr,
    input  logic [cpu_pkg::data_w-1:0] pc,
    output logic [cpu_pkg::reg_aw-1:0] ra_addr,
    output logic [cpu_pkg::reg_aw-1:0] rb_addr,
    input  logic [cpu_pkg::data_w-1:0] ra_data,
    input  logic [cpu_pkg::data_w-1:0] rb_data,
    input  logic ra_flag,
    issue_if.issue iss
);
    import cpu_pkg::*;

    logic rform;
    logic [data_w-1:0] imm_ext;

    assign rform = instr.r.opcode inside {op_add, op_sub, op_and, op_or, op_xor,
                                          op_shl, op_shr};
    assign imm_ext = rform ? '0 : {{(data_w-imm_w){instr.i.imm[imm_w-1]}}, instr.i.imm};

    assign ra_addr = instr.r.ra;
    // Port b reads rd for stores
    assign rb_addr = rform ? instr.r.rb : instr.i.rd;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            iss.valid <= 1'b0;
        end else begin
            iss.valid <= instr_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (instr_valid) begin
            iss.opcode <= instr.r.opcode;
            iss.rd <= instr.r.rd;
            iss.op_a <= ra_data;
            iss.op_b <= rb_data;
            iss.imm <= imm_ext;
            iss.flag_a <= ra_flag;
            iss.pc <= pc;
        end
    end

    a_legal_opcode: assert property (@(posedge clock) disable iff (!arst_n)
        instr_valid |-> instr.r.opcode inside {op_add, op_sub, op_and, op_or, op_xor,
                                               op_shl, op_shr, op_addi, op_ldi, op_ld,
                                               op_st, op_bz, op_bnz, op_jmp, op_halt})
        else $error("undefined opcode fetched at pc %0d", pc);

endmodule

`default_nettype wire

// File: cpu_execute.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_execute (
    input  logic clock,
    input  logic arst_n,
    issue_if.accept iss,
    bus_req_if.master bus,
    output logic we,
    output logic [cpu_pkg::reg_aw-1:0] waddr,
    output logic [cpu_pkg::data_w-1:0] wdata,
    output logic halted
);
    import cpu_pkg::*;

    logic [data_w-1:0] alu_out;
    logic [data_w-1:0] eff_addr;
    logic alu_wb;
    logic is_mem;
    logic taken;
    logic ld_pend;
    logic [reg_aw-1:0] ld_rd;

    always_comb begin
        case (iss.opcode)
            op_add: alu_out = iss.op_a + iss.op_b;
            op_sub: alu_out = iss.op_a - iss.op_b;
            op_and: alu_out = iss.op_a & iss.op_b;
            op_or: alu_out = iss.op_a | iss.op_b;
            op_xor: alu_out = iss.op_a ^ iss.op_b;
            op_shl: alu_out = iss.op_a << iss.op_b[4:0];
            op_shr: alu_out = iss.op_a >> iss.op_b[4:0];
            op_ldi: alu_out = iss.imm;
            default: alu_out = iss.op_a + iss.imm;    // addi
        endcase
    end

    assign eff_addr = iss.op_a + iss.imm;    // ld, st and jmp
    assign alu_wb = iss.opcode inside {op_add, op_sub, op_and, op_or, op_xor, op_shl,
                                       op_shr, op_addi, op_ldi};
    assign is_mem = (iss.opcode == op_ld) || (iss.opcode == op_st);
    assign taken = ((iss.opcode == op_bz) && iss.flag_a)
                || ((iss.opcode == op_bnz) && !iss.flag_a);

    assign bus.req = iss.valid && is_mem;
    assign bus.rw = (iss.opcode == op_st);
    assign bus.addr = eff_addr;
    assign bus.wdata = iss.op_b;    // value of rd
    assign bus.redirect = iss.valid && (taken || iss.opcode == op_jmp);
    assign bus.target = (iss.opcode == op_jmp) ? eff_addr : iss.pc + 1 + iss.imm;
    // Loads retire when their data is back, halt never retires
    assign bus.done = (iss.valid && iss.opcode != op_ld && iss.opcode != op_halt)
                   || bus.ld_valid;

    assign we = (iss.valid && alu_wb) || bus.ld_valid;
    assign waddr = bus.ld_valid ? ld_rd : iss.rd;
    assign wdata = bus.ld_valid ? bus.ld_data : alu_out;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            ld_pend <= 1'b0;
            halted <= 1'b0;
        end else begin
            if (bus.req && !bus.rw) begin
                ld_pend <= 1'b1;
            end else if (bus.ld_valid) begin
                ld_pend <= 1'b0;
            end
            if (iss.valid && iss.opcode == op_halt) begin
                halted <= 1'b1;    // sticky until reset
            end
        end
    end

    always_ff @(posedge clock) begin
        if (bus.req && !bus.rw) begin
            ld_rd <= iss.rd;
        end
    end

    a_no_issue_in_load: assert property (@(posedge clock) disable iff (!arst_n)
        ld_pend |-> !iss.valid)
        else $error("new instruction issued while a load is pending");

endmodule

`default_nettype wire

// File: cpu_core.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_core (
    input  logic clock,
    input  logic arst_n,
    input  logic [cpu_pkg::data_w-1:0] data,
    output logic [cpu_pkg::data_w-1:0] datao,
    output logic [cpu_pkg::data_w-1:0] address,
    output logic rw,
    output logic mem_req,
    output logic halted
);
    import cpu_pkg::*;

    logic instr_valid;
    instr_u instr;
    logic [data_w-1:0] pc;
    logic [reg_aw-1:0] ra_addr;
    logic [reg_aw-1:0] rb_addr;
    logic [data_w-1:0] ra_data;
    logic [data_w-1:0] rb_data;
    logic ra_flag;
    logic we;
    logic [reg_aw-1:0] waddr;
    logic [data_w-1:0] wdata;

    issue_if iss ();
    bus_req_if bus ();

    cpu_fetch u_fetch (
        .clock       (clock),
        .arst_n      (arst_n),
        .data        (data),
        .address     (address),
        .datao       (datao),
        .rw          (rw),
        .mem_req     (mem_req),
        .instr_valid (instr_valid),
        .instr       (instr),
        .pc          (pc),
        .bus         (bus.slave)
    );

    cpu_decode u_decode (
        .clock       (clock),
        .arst_n      (arst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .pc          (pc),
        .ra_addr     (ra_addr),
        .rb_addr     (rb_addr),
        .ra_data     (ra_data),
        .rb_data     (rb_data),
        .ra_flag     (ra_flag),
        .iss         (iss.issue)
    );

    cpu_regfile u_regfile (
        .clock   (clock),
        .arst_n  (arst_n),
        .ra_addr (ra_addr),
        .rb_addr (rb_addr),
        .ra_data (ra_data),
        .rb_data (rb_data),
        .ra_flag (ra_flag),
        .we      (we),
        .waddr   (waddr),
        .wdata   (wdata)
    );

    cpu_execute u_execute (
        .clock  (clock),
        .arst_n (arst_n),
        .iss    (iss.accept),
        .bus    (bus.master),
        .we     (we),
        .waddr  (waddr),
        .wdata  (wdata),
        .halted (halted)
    );

endmodule

`default_nettype wire

// File: tb_cpu_checker.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_checker (
    input  logic clock,
    input  logic arst_n,
    input  logic mem_req,
    input  logic rw,
    input  logic [31:0] address,
    input  logic [31:0] datao,
    input  logic halted
);
    string test_name;
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    logic [31:0] want_addr;
    logic [31:0] want_data;
    logic halt_seen;
    int mismatch_count;
    int fault_count;

    initial begin
        test_name = "";
        halt_seen = 1'b0;
        mismatch_count = 0;
        fault_count = 0;
    end

    task automatic begin_test(input string name);
        test_name = name;
        exp_addr.delete();
        exp_data.delete();
        halt_seen = 1'b0;
    endtask

    task automatic expect_store(input logic [31:0] addr, input logic [31:0] value);
        exp_addr.push_back(addr);
        exp_data.push_back(value);
    endtask

    // Bus outputs are settled by the falling edge
    always @(negedge clock) begin
        if (arst_n) begin
            if (halt_seen && mem_req) begin
                $display("test %s: bus request to address 0x%0h after halt", test_name, address);
                fault_count++;
            end else if (mem_req && rw) begin
                if (exp_addr.size() == 0) begin
                    $display("test %s: extra store of 0x%08h to address 0x%0h",
                             test_name, datao, address);
                    fault_count++;
                end else begin
                    want_addr = exp_addr.pop_front();
                    want_data = exp_data.pop_front();
                    if (address !== want_addr || datao !== want_data) begin
                        $display("mismatch %s: expected 0x%08h at 0x%0h, actual 0x%08h at 0x%0h",
                                 test_name, want_data, want_addr, datao, address);
                        mismatch_count++;
                    end
                end
            end
            if (halt_seen && !halted) begin
                $display("test %s: halted went low again", test_name);
                fault_count++;
                halt_seen = 1'b0;
            end else if (halted && !halt_seen) begin
                halt_seen = 1'b1;
                if (exp_addr.size() != 0) begin
                    $display("test %s: %0d expected stores missing at halt",
                             test_name, exp_addr.size());
                    fault_count++;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: tb_cpu_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_core;
    logic clock;
    logic arst_n;
    logic [31:0] data;
    logic [31:0] datao;
    logic [31:0] address;
    logic rw;
    logic mem_req;
    logic halted;

    logic [31:0] mem [256];
    logic [31:0] rd_word;
    logic rd_due;

    // Parsed tests with their program and expected entries in flat queues
    string names [$];
    int p_first [$];
    int e_first [$];
    logic [31:0] p_addr [$];
    logic [31:0] p_word [$];
    logic [31:0] e_addr [$];
    logic [31:0] e_data [$];
    int tb_errors;
    int cycles;
    int limit;

    cpu_core u_dut (
        .clock   (clock),
        .arst_n  (arst_n),
        .data    (data),
        .datao   (datao),
        .address (address),
        .rw      (rw),
        .mem_req (mem_req),
        .halted  (halted)
    );

    tb_cpu_checker u_check (
        .clock   (clock),
        .arst_n  (arst_n),
        .mem_req (mem_req),
        .rw      (rw),
        .address (address),
        .datao   (datao),
        .halted  (halted)
    );

    initial clock = 1'b0;
    always #20 clock = ~clock;

    // Memory samples the request mid-cycle and answers after the next edge
    always @(negedge clock) begin
        rd_due = 1'b0;
        if (arst_n && mem_req) begin
            if (rw) begin
                mem[address[7:0]] = datao;
            end else begin
                rd_word = mem[address[7:0]];
                rd_due = 1'b1;
            end
        end
    end

    always @(posedge clock) begin
        if (rd_due) begin
            #2;
            data = rd_word;
        end
    end

    always @(posedge clock) begin
        cycles++;
        if (limit > 0 && cycles > limit) begin
            $display("timeout: no halt within %0d cycles", limit);
            tb_errors++;
            report_counts();
            $display("RESULT: FAIL");
            $finish;
        end
    end

    task automatic report_counts();
        $display("errors: %0d mismatch, %0d other checker, %0d testbench",
                 u_check.mismatch_count, u_check.fault_count, tb_errors);
    endtask

    task automatic read_tests();
        int fd;
        string line;
        string nm;
        logic [31:0] a;
        logic [31:0] w;
        fd = $fopen("cpu_core_input.txt", "r");
        if (fd == 0) begin
            $display("cannot open cpu_core_input.txt");
            tb_errors++;
            return;
        end
        while ($fgets(line, fd) != 0) begin
            if (line.getc(0) == "T") begin
                void'($sscanf(line, "T %s", nm));
                names.push_back(nm);
                p_first.push_back(p_addr.size());
                e_first.push_back(e_addr.size());
            end else if (line.getc(0) == "P") begin
                void'($sscanf(line, "P %h %h", a, w));
                p_addr.push_back(a);
                p_word.push_back(w);
            end else if (line.getc(0) == "E") begin
                void'($sscanf(line, "E %h %h", a, w));
                e_addr.push_back(a);
                e_data.push_back(w);
            end
        end
        $fclose(fd);
    endtask

    task automatic run_test(input int k);
        int p_end;
        int e_end;
        p_end = (k + 1 < names.size()) ? p_first[k+1] : p_addr.size();
        e_end = (k + 1 < names.size()) ? e_first[k+1] : e_addr.size();
        @(posedge clock);
        #2;
        arst_n = 1'b0;
        for (int i = 0; i < 256; i++) begin
            mem[i] = '0;
        end
        for (int i = p_first[k]; i < p_end; i++) begin
            mem[p_addr[i][7:0]] = p_word[i];
        end
        u_check.begin_test(names[k]);
        for (int i = e_first[k]; i < e_end; i++) begin
            u_check.expect_store(e_addr[i], e_data[i]);
        end
        repeat (5) @(posedge clock);
        #2;
        arst_n = 1'b1;
        do begin
            @(posedge clock);
            #2;
        end while (!halted);
        repeat (6) @(posedge clock);    // bus must stay quiet here
    endtask

    initial begin
        arst_n = 1'b0;
        data = '0;
        rd_due = 1'b0;
        tb_errors = 0;
        cycles = 0;
        limit = 0;
        read_tests();
        limit = 100 * names.size() + 8 * p_addr.size();
        if (names.size() == 0) begin
            $display("no tests found in cpu_core_input.txt");
            tb_errors++;
        end
        for (int k = 0; k < names.size(); k++) begin
            run_test(k);
        end
        report_counts();
        if (u_check.mismatch_count + u_check.fault_count + tb_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: cpu_core.f
cpu_pkg.sv
cpu_if.sv
cpu_fetch.sv
cpu_regfile.sv
cpu_decode.sv
cpu_execute.sv
cpu_core.sv
tb_cpu_checker.sv
tb_cpu_core.sv

// File: Makefile
TOP = tb_cpu_core

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f cpu_core.f --top-module $(TOP) -Mdir obj_dir

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "RESULT: PASS" sim.log

lint:
	verilator --lint-only -Wall --top-module cpu_core cpu_pkg.sv cpu_if.sv cpu_fetch.sv \
		cpu_regfile.sv cpu_decode.sv cpu_execute.sv cpu_core.sv

clean:
	rm -rf obj_dir sim.log

// File: cpu_core_input.txt
# T name | P word_addr instr_word | E store_addr store_value (expected order)
# All numbers hex, addresses are word addresses
T alu
P 00 2480000C
P 01 25000005
P 02 01940000
P 03 2D800080
P 04 05940000
P 05 2D800081
P 06 09940000
P 07 2D800082
P 08 0D940000
P 09 2D800083
P 0A 11940000
P 0B 2D800084
P 0C 15940000
P 0D 2D800085
P 0E 1A340000
P 0F 2E000086
P 10 2290FFEC
P 11 2E800087
P 12 3C000000
E 80 00000011
E 81 00000007
E 82 00000004
E 83 0000000D
E 84 00000009
E 85 00000180
E 86 0000000C
E 87 FFFFFFF8
T flags
P 00 30700001
P 01 2C000090
P 02 24800003
P 03 34100001
P 04 2C000090
P 05 30100001
P 06 2C800090
P 07 04920000
P 08 34100001
P 09 25000007
P 0A 30100001
P 0B 2C000091
P 0C 2D000091
P 0D 3C000000
E 90 00000003
E 91 00000007
T load_store
P 00 24801234
P 01 2C8000A0
P 02 290000A0
P 03 21A00001
P 04 2D8000A1
P 05 3C000000
E A0 00001234
E A1 00001235
T loop
P 00 24800003
P 01 2C9000B0
P 02 2090FFFF
P 03 3410FFFD
P 04 38000006
P 05 2C0000BF
P 06 2C8000B0
P 07 3C000000
E B3 00000003
E B2 00000002
E B1 00000001
E B0 00000000
